/* rs_subsystem.f */
verilog/rs_pkg.sv
verilog/priority_select.sv
verilog/rs_tag_cam.sv
verilog/rs_issue_port.sv
verilog/reservation_station.sv
verilog/rs_subsystem.sv
test/rs_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module rs_tb -f rs_subsystem.f -o rs_tb_sim
./obj_dir/rs_tb_sim | tee sim.log

# Result comes from the log, not from the simulator status
if grep -qx "all tests passed" sim.log; then
	echo "simulation result: pass"
	exit 0
else
	echo "simulation result: fail"
	exit 1
fi

/* test/rs_tb.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the reservation station top level
// Table model, compare tasks, cycle limit, summary
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_tb;

	localparam int rs_size   = 8;
	localparam int tag_width = 6;
	// Reset, directed tests, random mix with tag sweep, margin
	localparam int cycle_limit = 5 + 40 + 3 * rs_size + 200 + 2**tag_width + rs_size + 100;

	typedef logic [tag_width-1:0] tag_t;

	logic              clock = 1'b0;
	logic              reset;
	logic              dispatch_valid;
	rs_pkg::fu_class_t dispatch_class;
	rs_pkg::op_t       dispatch_op;
	tag_t              dispatch_dest;
	tag_t              dispatch_src1;
	logic              dispatch_src1_ready;
	tag_t              dispatch_src2;
	logic              dispatch_src2_ready;
	logic              dispatch_ready;
	logic              cdb_valid;
	tag_t              cdb_tag;
	// Port index 0 alu, 1 mult, 2 mem
	logic [2:0]        issue_ready;
	logic [2:0]        issue_valid;
	rs_pkg::op_t       issue_op [3];
	tag_t              issue_dest [3];

	// Table model
	logic              m_busy  [rs_size];
	rs_pkg::fu_class_t m_class [rs_size];
	rs_pkg::op_t       m_op    [rs_size];
	tag_t              m_dest  [rs_size];
	tag_t              m_src1  [rs_size];
	tag_t              m_src2  [rs_size];
	logic              m_rdy1  [rs_size];
	logic              m_rdy2  [rs_size];

	logic [31:0] rng = 32'h2d395002;
	string       test_name;
	int          error_count = 0;
	int          errors_at_start;
	int          tests_run = 0;
	int          tests_bad = 0;
	int          cycle_count = 0;
	logic        last_accept = 1'b0;

	rs_subsystem #(
		.rs_size  (rs_size),
		.tag_width(tag_width)
	) u_rs_subsystem (
		.clock              (clock),
		.reset              (reset),
		.dispatch_valid     (dispatch_valid),
		.dispatch_class     (dispatch_class),
		.dispatch_op        (dispatch_op),
		.dispatch_dest      (dispatch_dest),
		.dispatch_src1      (dispatch_src1),
		.dispatch_src1_ready(dispatch_src1_ready),
		.dispatch_src2      (dispatch_src2),
		.dispatch_src2_ready(dispatch_src2_ready),
		.dispatch_ready     (dispatch_ready),
		.cdb_valid          (cdb_valid),
		.cdb_tag            (cdb_tag),
		.alu_issue_ready    (issue_ready[0]),
		.alu_issue_valid    (issue_valid[0]),
		.alu_issue_op       (issue_op[0]),
		.alu_issue_dest     (issue_dest[0]),
		.mult_issue_ready   (issue_ready[1]),
		.mult_issue_valid   (issue_valid[1]),
		.mult_issue_op      (issue_op[1]),
		.mult_issue_dest    (issue_dest[1]),
		.mem_issue_ready    (issue_ready[2]),
		.mem_issue_valid    (issue_valid[2]),
		.mem_issue_op       (issue_op[2]),
		.mem_issue_dest     (issue_dest[2])
	);

	always #2 clock = ~clock;

	// Run limit
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic string class_label(input int c);
		case (c)
			0: return "alu";
			1: return "mult";
			default: return "mem";
		endcase
	endfunction

	// Highest busy entry of the class with both sources ready
	function automatic int pick_issue(input int c);
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (m_busy[i] && m_rdy1[i] && m_rdy2[i] && m_class[i] == rs_pkg::fu_class_t'(c)) begin
				return i;
			end
		end
		return -1;
	endfunction

	// Highest free entry
	function automatic int pick_free();
		for (int i = rs_size - 1; i >= 0; i--) begin
			if (!m_busy[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic check_op(input string what, input rs_pkg::op_t expected,
			input rs_pkg::op_t actual);
		if (actual !== expected) begin
			$display("error %s %s expected %h actual %h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_tag(input string what, input tag_t expected, input tag_t actual);
		if (actual !== expected) begin
			$display("error %s %s expected %h actual %h", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error %s %s expected %b actual %b", test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count != errors_at_start) begin
			tests_bad++;
		end
		$display("%s: %0d errors", test_name, error_count - errors_at_start);
	endtask

	task automatic idle();
		dispatch_valid = 1'b0;
		cdb_valid = 1'b0;
	endtask

	task automatic drive_dispatch(input rs_pkg::fu_class_t cls, input rs_pkg::op_t op,
			input tag_t dest, input tag_t s1, input logic r1, input tag_t s2, input logic r2);
		dispatch_valid = 1'b1;
		dispatch_class = cls;
		dispatch_op = op;
		dispatch_dest = dest;
		dispatch_src1 = s1;
		dispatch_src1_ready = r1;
		dispatch_src2 = s2;
		dispatch_src2_ready = r2;
	endtask

	task automatic broadcast(input tag_t tag);
		cdb_valid = 1'b1;
		cdb_tag = tag;
	endtask

	////////////////////////////////////////////////////////////
	// One clock cycle, model check then model update
	////////////////////////////////////////////////////////////

	task automatic step();
		int sel [3];
		int slot;
		#1;
		slot = pick_free();
		check_bit("dispatch_ready", slot >= 0, dispatch_ready);
		for (int c = 0; c < 3; c++) begin
			sel[c] = pick_issue(c);
			check_bit({class_label(c), " valid"}, sel[c] >= 0, issue_valid[c]);
			if (sel[c] >= 0) begin
				check_op({class_label(c), " op"}, m_op[sel[c]], issue_op[c]);
				check_tag({class_label(c), " dest"}, m_dest[sel[c]], issue_dest[c]);
			end
		end
		last_accept = dispatch_valid && slot >= 0;
		@(posedge clock);
		// Release on transfer
		for (int c = 0; c < 3; c++) begin
			if (sel[c] >= 0 && issue_ready[c]) begin
				m_busy[sel[c]] = 1'b0;
			end
		end
		// Wakeup of waiting sources
		for (int i = 0; i < rs_size; i++) begin
			if (m_busy[i] && cdb_valid && m_src1[i] == cdb_tag) begin
				m_rdy1[i] = 1'b1;
			end
			if (m_busy[i] && cdb_valid && m_src2[i] == cdb_tag) begin
				m_rdy2[i] = 1'b1;
			end
		end
		// Allocation with same-cycle bypass
		if (last_accept) begin
			m_busy[slot] = 1'b1;
			m_class[slot] = dispatch_class;
			m_op[slot] = dispatch_op;
			m_dest[slot] = dispatch_dest;
			m_src1[slot] = dispatch_src1;
			m_src2[slot] = dispatch_src2;
			m_rdy1[slot] = dispatch_src1_ready || (cdb_valid && dispatch_src1 == cdb_tag);
			m_rdy2[slot] = dispatch_src2_ready || (cdb_valid && dispatch_src2 == cdb_tag);
		end
		@(negedge clock);
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_issue();
		rs_pkg::op_t op;
		tag_t        dest;
		begin_test("reset_issue");
		for (int c = 0; c < 3; c++) begin
			check_bit({class_label(c), " valid after reset"}, 1'b0, issue_valid[c]);
		end
		check_bit("dispatch_ready after reset", 1'b1, dispatch_ready);
		rng = xorshift32(rng);
		op = rng[7:0];
		dest = rng[13:8];
		drive_dispatch(rs_pkg::fu_alu, op, dest, 6'h01, 1'b1, 6'h02, 1'b1);
		step();
		idle();
		check_bit("alu valid next cycle", 1'b1, issue_valid[0]);
		check_op("alu op", op, issue_op[0]);
		check_tag("alu dest", dest, issue_dest[0]);
		step();
		check_bit("alu valid after issue", 1'b0, issue_valid[0]);
		end_test();
	endtask

	task automatic test_wakeup();
		rs_pkg::op_t op;
		tag_t        dest;
		begin_test("wakeup");
		rng = xorshift32(rng);
		op = rng[7:0];
		dest = rng[13:8];
		drive_dispatch(rs_pkg::fu_mult, op, dest, 6'h11, 1'b0, 6'h22, 1'b0);
		step();
		idle();
		// Unrelated tag first
		broadcast(6'h33);
		step();
		check_bit("mult valid after unrelated tag", 1'b0, issue_valid[1]);
		broadcast(6'h11);
		step();
		check_bit("mult valid after first tag", 1'b0, issue_valid[1]);
		broadcast(6'h22);
		step();
		idle();
		check_bit("mult valid after second tag", 1'b1, issue_valid[1]);
		check_op("mult op", op, issue_op[1]);
		check_tag("mult dest", dest, issue_dest[1]);
		step();
		check_bit("mult valid after issue", 1'b0, issue_valid[1]);
		end_test();
	endtask

	task automatic test_bypass();
		rs_pkg::op_t op;
		tag_t        dest;
		begin_test("bypass");
		rng = xorshift32(rng);
		op = rng[7:0];
		dest = rng[13:8];
		// Broadcast meets the dispatching source
		drive_dispatch(rs_pkg::fu_alu, op, dest, 6'h2a, 1'b0, 6'h05, 1'b1);
		broadcast(6'h2a);
		step();
		idle();
		check_bit("alu valid after bypass", 1'b1, issue_valid[0]);
		check_op("alu op", op, issue_op[0]);
		check_tag("alu dest", dest, issue_dest[0]);
		step();
		end_test();
	endtask

	task automatic test_full_backpressure();
		rs_pkg::op_t op_q [$];
		tag_t        dest_q [$];
		begin_test("full_backpressure");
		issue_ready[2] = 1'b0;
		for (int k = 0; k < rs_size; k++) begin
			rng = xorshift32(rng);
			op_q.push_back(rng[7:0]);
			dest_q.push_back(rng[13:8]);
			drive_dispatch(rs_pkg::fu_mem, rng[7:0], rng[13:8], 6'h03, 1'b1, 6'h04, 1'b1);
			step();
		end
		idle();
		check_bit("dispatch_ready when full", 1'b0, dispatch_ready);
		check_bit("mem valid while stalled", 1'b1, issue_valid[2]);
		// First dispatched sits in the highest entry
		issue_ready[2] = 1'b1;
		check_op("mem first drain", op_q.pop_front(), issue_op[2]);
		check_tag("mem first drain", dest_q.pop_front(), issue_dest[2]);
		step();
		issue_ready[2] = 1'b0;
		check_bit("dispatch_ready after one drain", 1'b1, dispatch_ready);
		rng = xorshift32(rng);
		drive_dispatch(rs_pkg::fu_alu, rng[7:0], rng[13:8], 6'h03, 1'b1, 6'h04, 1'b1);
		step();
		idle();
		check_bit("alu valid with mem stalled", 1'b1, issue_valid[0]);
		check_bit("mem still stalled", 1'b1, issue_valid[2]);
		step();
		check_bit("alu valid after issue", 1'b0, issue_valid[0]);
		issue_ready[2] = 1'b1;
		while (op_q.size() > 0) begin
			check_bit("mem valid in drain", 1'b1, issue_valid[2]);
			check_op("mem drain op", op_q.pop_front(), issue_op[2]);
			check_tag("mem drain dest", dest_q.pop_front(), issue_dest[2]);
			step();
		end
		check_bit("mem valid after drain", 1'b0, issue_valid[2]);
		end_test();
	endtask

	task automatic test_parallel_issue();
		rs_pkg::op_t op [3];
		tag_t        dest [3];
		begin_test("parallel_issue");
		issue_ready = 3'b000;
		for (int c = 0; c < 3; c++) begin
			rng = xorshift32(rng);
			op[c] = rng[7:0];
			dest[c] = rng[13:8];
			drive_dispatch(rs_pkg::fu_class_t'(c), op[c], dest[c], 6'h07, 1'b1, 6'h08, 1'b1);
			step();
		end
		idle();
		issue_ready = 3'b111;
		for (int c = 0; c < 3; c++) begin
			check_bit({class_label(c), " valid together"}, 1'b1, issue_valid[c]);
			check_op({class_label(c), " op"}, op[c], issue_op[c]);
			check_tag({class_label(c), " dest"}, dest[c], issue_dest[c]);
		end
		step();
		for (int c = 0; c < 3; c++) begin
			check_bit({class_label(c), " valid after issue"}, 1'b0, issue_valid[c]);
		end
		end_test();
	endtask

	task automatic test_random_mix();
		begin_test("random_mix");
		for (int n = 0; n < 200; n++) begin
			rng = xorshift32(rng);
			// Payload held until accepted
			if (!dispatch_valid || last_accept) begin
				drive_dispatch(rs_pkg::fu_class_t'(rng[3:2] == 2'd3 ? 2'd0 : rng[3:2]),
					rng[11:4], rng[17:12], rng[23:18], rng[24], rng[30:25], rng[31]);
				dispatch_valid = rng[0] | rng[1];
			end
			rng = xorshift32(rng);
			cdb_valid = rng[0];
			cdb_tag = rng[6:1];
			issue_ready = rng[9:7] | rng[12:10];
			step();
		end
		// Sweep every tag so all waiting entries drain
		idle();
		issue_ready = 3'b111;
		for (int t = 0; t < 2**tag_width; t++) begin
			broadcast(tag_t'(t));
			step();
		end
		idle();
		repeat (rs_size) step();
		// Every source was broadcast, so the table must be empty now
		check_bit("dispatch_ready after sweep", 1'b1, dispatch_ready);
		for (int c = 0; c < 3; c++) begin
			check_bit({class_label(c), " valid after sweep"}, 1'b0, issue_valid[c]);
		end
		end_test();
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset = 1'b1;
		idle();
		drive_dispatch(rs_pkg::fu_alu, '0, '0, '0, 1'b0, '0, 1'b0);
		dispatch_valid = 1'b0;
		cdb_tag = '0;
		issue_ready = 3'b111;
		for (int i = 0; i < rs_size; i++) begin
			m_busy[i] = 1'b0;
			m_rdy1[i] = 1'b0;
			m_rdy2[i] = 1'b0;
		end
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		test_reset_issue();
		test_wakeup();
		test_bypass();
		test_full_backpressure();
		test_parallel_issue();
		test_random_mix();

		$display("summary: %0d tests run, %0d with errors, %0d wrong checks",
			tests_run, tests_bad, error_count);
		if (error_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* verilog/priority_select.sv */
////////////////////////////////////////////////////////////
// Two-level fixed-priority selector, highest index wins
// Request padded to groups of four, group OR feeds top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module priority_select #(
	parameter int width = 8
) (
	input  logic [width-1:0] request,
	output logic [width-1:0] grant,
	output logic             any
);

	localparam int num_groups   = (width + 3) / 4;
	localparam int padded_width = 4 * num_groups;

	logic [padded_width-1:0] req_pad;
	logic [padded_width-1:0] grant_pad;
	logic [num_groups-1:0]   group_req;
	logic [num_groups-1:0]   group_grant;

	// Four-wide leaf, bit 3 has priority
	function automatic logic [3:0] pick4(input logic [3:0] req);
		logic [3:0] gnt;
		gnt[3] = req[3];
		gnt[2] = req[2] & ~req[3];
		gnt[1] = req[1] & ~|req[3:2];
		gnt[0] = req[0] & ~|req[3:1];
		return gnt;
	endfunction

	// Zero pad up to a whole number of groups
	assign req_pad = padded_width'(request);

	// Bottom level, one leaf per group
	for (genvar g = 0; g < num_groups; g++) begin : gen_group
		assign group_req[g] = |req_pad[4*g +: 4];
		assign grant_pad[4*g +: 4] = group_grant[g] ? pick4(req_pad[4*g +: 4]) : 4'b0000;
	end

	// Top level, highest requesting group
	always_comb begin
		logic found;
		found = 1'b0;
		group_grant = '0;
		for (int g = num_groups - 1; g >= 0; g--) begin
			if (group_req[g] && !found) begin
				group_grant[g] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// Padding bits never request, so dropping them is safe
	assign grant = grant_pad[width-1:0];
	assign any   = |group_req;

endmodule

/* verilog/reservation_station.sv */
////////////////////////////////////////////////////////////
// Reservation station entry table
// Allocation, CDB wakeup with dispatch bypass, release
// Three per-class issue ports: alu, mult, mem
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module reservation_station #(
	parameter int rs_size   = 8,
	parameter int tag_width = 6
) (
	input  logic                 clock,
	input  logic                 reset,
	// Dispatch
	input  logic                 dispatch_valid,
	input  rs_pkg::fu_class_t    dispatch_class,
	input  rs_pkg::op_t          dispatch_op,
	input  logic [tag_width-1:0] dispatch_dest,
	input  logic [tag_width-1:0] dispatch_src1,
	input  logic                 dispatch_src1_ready,
	input  logic [tag_width-1:0] dispatch_src2,
	input  logic                 dispatch_src2_ready,
	output logic                 dispatch_ready,
	// Common data bus
	input  logic                 cdb_valid,
	input  logic [tag_width-1:0] cdb_tag,
	// ALU issue
	input  logic                 alu_issue_ready,
	output logic                 alu_issue_valid,
	output rs_pkg::op_t          alu_issue_op,
	output logic [tag_width-1:0] alu_issue_dest,
	// Multiplier issue
	input  logic                 mult_issue_ready,
	output logic                 mult_issue_valid,
	output rs_pkg::op_t          mult_issue_op,
	output logic [tag_width-1:0] mult_issue_dest,
	// Memory issue
	input  logic                 mem_issue_ready,
	output logic                 mem_issue_valid,
	output rs_pkg::op_t          mem_issue_op,
	output logic [tag_width-1:0] mem_issue_dest
);

	////////////////////////////////////////////////////////////
	// Entry table
	////////////////////////////////////////////////////////////

	logic [rs_size-1:0]   busy;
	rs_pkg::fu_class_t    entry_class [rs_size];
	rs_pkg::op_t          entry_op    [rs_size];
	logic [tag_width-1:0] entry_dest  [rs_size];
	logic [tag_width-1:0] src1_tag    [rs_size];
	logic [tag_width-1:0] src2_tag    [rs_size];
	logic [rs_size-1:0]   src1_rdy;
	logic [rs_size-1:0]   src2_rdy;

	// Combinational control
	logic [rs_size-1:0] alloc_grant;
	logic [rs_size-1:0] entry_ready;
	logic [rs_size-1:0] released;
	logic [rs_size-1:0] src1_hit;
	logic [rs_size-1:0] src2_hit;
	logic [rs_size-1:0] issue_grant [rs_pkg::num_fu_class];
	logic               dispatch_src1_hit;
	logic               dispatch_src2_hit;
	logic               dispatch_fire;

	////////////////////////////////////////////////////////////
	// Allocation
	////////////////////////////////////////////////////////////

	// Highest free entry, any free slot opens dispatch
	priority_select #(
		.width(rs_size)
	) u_alloc_select (
		.request(~busy),
		.grant  (alloc_grant),
		.any    (dispatch_ready)
	);

	assign dispatch_fire = dispatch_valid && dispatch_ready;

	////////////////////////////////////////////////////////////
	// Wakeup
	////////////////////////////////////////////////////////////

	rs_tag_cam #(
		.rs_size  (rs_size),
		.tag_width(tag_width)
	) u_tag_cam (
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.src1_tags        (src1_tag),
		.src2_tags        (src2_tag),
		.dispatch_src1    (dispatch_src1),
		.dispatch_src2    (dispatch_src2),
		.src1_hit         (src1_hit),
		.src2_hit         (src2_hit),
		.dispatch_src1_hit(dispatch_src1_hit),
		.dispatch_src2_hit(dispatch_src2_hit)
	);

	////////////////////////////////////////////////////////////
	// Issue
	////////////////////////////////////////////////////////////

	// Registered state only, wakeups count from the next cycle
	assign entry_ready = busy & src1_rdy & src2_rdy;

	rs_issue_port #(
		.rs_size    (rs_size),
		.tag_width  (tag_width),
		.serve_class(rs_pkg::fu_alu)
	) u_alu_port (
		.entry_ready(entry_ready),
		.entry_class(entry_class),
		.entry_op   (entry_op),
		.entry_dest (entry_dest),
		.issue_ready(alu_issue_ready),
		.issue_valid(alu_issue_valid),
		.issue_op   (alu_issue_op),
		.issue_dest (alu_issue_dest),
		.issue_grant(issue_grant[rs_pkg::fu_alu])
	);

	rs_issue_port #(
		.rs_size    (rs_size),
		.tag_width  (tag_width),
		.serve_class(rs_pkg::fu_mult)
	) u_mult_port (
		.entry_ready(entry_ready),
		.entry_class(entry_class),
		.entry_op   (entry_op),
		.entry_dest (entry_dest),
		.issue_ready(mult_issue_ready),
		.issue_valid(mult_issue_valid),
		.issue_op   (mult_issue_op),
		.issue_dest (mult_issue_dest),
		.issue_grant(issue_grant[rs_pkg::fu_mult])
	);

	// Memory port ready acts as LSQ back-pressure
	rs_issue_port #(
		.rs_size    (rs_size),
		.tag_width  (tag_width),
		.serve_class(rs_pkg::fu_mem)
	) u_mem_port (
		.entry_ready(entry_ready),
		.entry_class(entry_class),
		.entry_op   (entry_op),
		.entry_dest (entry_dest),
		.issue_ready(mem_issue_ready),
		.issue_valid(mem_issue_valid),
		.issue_op   (mem_issue_op),
		.issue_dest (mem_issue_dest),
		.issue_grant(issue_grant[rs_pkg::fu_mem])
	);

	// Grants are already qualified by issue_ready
	always_comb begin
		released = '0;
		for (int c = 0; c < rs_pkg::num_fu_class; c++) begin
			released = released | issue_grant[c];
		end
	end

	////////////////////////////////////////////////////////////
	// State update
	////////////////////////////////////////////////////////////

	// Busy flags, release and allocate never hit the same entry
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= '0;
		end else begin
			for (int i = 0; i < rs_size; i++) begin
				if (released[i]) begin
					busy[i] <= 1'b0;
				end
				if (dispatch_fire && alloc_grant[i]) begin
					busy[i] <= 1'b1;
				end
			end
		end
	end

	// Payload and source readiness, meaningful only while busy
	always_ff @(posedge clock) begin
		for (int i = 0; i < rs_size; i++) begin
			if (busy[i] && src1_hit[i]) begin
				src1_rdy[i] <= 1'b1;
			end
			if (busy[i] && src2_hit[i]) begin
				src2_rdy[i] <= 1'b1;
			end
			if (dispatch_fire && alloc_grant[i]) begin
				entry_class[i] <= dispatch_class;
				entry_op[i]    <= dispatch_op;
				entry_dest[i]  <= dispatch_dest;
				src1_tag[i]    <= dispatch_src1;
				src2_tag[i]    <= dispatch_src2;
				// Bypass of the broadcast in the dispatch cycle
				src1_rdy[i]    <= dispatch_src1_ready | dispatch_src1_hit;
				src2_rdy[i]    <= dispatch_src2_ready | dispatch_src2_hit;
			end
		end
	end

endmodule

/* verilog/rs_issue_port.sv */
////////////////////////////////////////////////////////////
// Issue port for one function-unit class
// Class mask, entry select, payload mux, qualified grant
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_issue_port #(
	parameter int               rs_size     = 8,
	parameter int               tag_width   = 6,
	parameter rs_pkg::fu_class_t serve_class = rs_pkg::fu_alu
) (
	input  logic [rs_size-1:0]     entry_ready,
	input  rs_pkg::fu_class_t      entry_class [rs_size],
	input  rs_pkg::op_t            entry_op    [rs_size],
	input  logic [tag_width-1:0]   entry_dest  [rs_size],
	input  logic                   issue_ready,
	output logic                   issue_valid,
	output rs_pkg::op_t            issue_op,
	output logic [tag_width-1:0]   issue_dest,
	output logic [rs_size-1:0]     issue_grant
);

	logic [rs_size-1:0] class_request;
	logic [rs_size-1:0] select;

	////////////////////////////////////////////////////////////
	// Request and select
	////////////////////////////////////////////////////////////

	// Ready entries of this class only
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			class_request[i] = entry_ready[i] && (entry_class[i] == serve_class);
		end
	end

	// Highest ready entry of the class wins
	priority_select #(
		.width(rs_size)
	) u_select (
		.request(class_request),
		.grant  (select),
		.any    (issue_valid)
	);

	////////////////////////////////////////////////////////////
	// Payload mux
	////////////////////////////////////////////////////////////

	// AND-OR mux, select is one-hot or zero
	always_comb begin
		issue_op   = '0;
		issue_dest = '0;
		for (int i = 0; i < rs_size; i++) begin
			if (select[i]) begin
				issue_op   = issue_op | entry_op[i];
				issue_dest = issue_dest | entry_dest[i];
			end
		end
	end

	// Entry leaves only on an actual transfer
	assign issue_grant = select & {rs_size{issue_ready}};

endmodule

/* verilog/rs_pkg.sv */
////////////////////////////////////////////////////////////
// Shared types for the reservation station
// Function-unit class encoding, opcode type, class count
////////////////////////////////////////////////////////////

package rs_pkg;

	////////////////////////////////////////////////////////////
	// Issue classes
	////////////////////////////////////////////////////////////

	// One issue port per class
	localparam int num_fu_class = 3;

	// Class encoding doubles as the issue port index
	typedef enum logic [1:0] {
		fu_alu  = 2'd0,
		fu_mult = 2'd1,
		fu_mem  = 2'd2
	} fu_class_t;

	////////////////////////////////////////////////////////////
	// Opcode
	////////////////////////////////////////////////////////////

	// Opaque to the window, only carried to the unit
	localparam int op_width = 8;

	typedef logic [op_width-1:0] op_t;

endpackage

/* verilog/rs_subsystem.sv */
////////////////////////////////////////////////////////////
// Top level of the scheduling window
// Sets table size and tag width, wraps the station
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_subsystem #(
	parameter int rs_size   = 8,
	parameter int tag_width = 6
) (
	input  logic                 clock,
	input  logic                 reset,
	// Dispatch
	input  logic                 dispatch_valid,
	input  rs_pkg::fu_class_t    dispatch_class,
	input  rs_pkg::op_t          dispatch_op,
	input  logic [tag_width-1:0] dispatch_dest,
	input  logic [tag_width-1:0] dispatch_src1,
	input  logic                 dispatch_src1_ready,
	input  logic [tag_width-1:0] dispatch_src2,
	input  logic                 dispatch_src2_ready,
	output logic                 dispatch_ready,
	// Common data bus
	input  logic                 cdb_valid,
	input  logic [tag_width-1:0] cdb_tag,
	// ALU issue
	input  logic                 alu_issue_ready,
	output logic                 alu_issue_valid,
	output rs_pkg::op_t          alu_issue_op,
	output logic [tag_width-1:0] alu_issue_dest,
	// Multiplier issue
	input  logic                 mult_issue_ready,
	output logic                 mult_issue_valid,
	output rs_pkg::op_t          mult_issue_op,
	output logic [tag_width-1:0] mult_issue_dest,
	// Memory issue
	input  logic                 mem_issue_ready,
	output logic                 mem_issue_valid,
	output rs_pkg::op_t          mem_issue_op,
	output logic [tag_width-1:0] mem_issue_dest
);

	// Station with CAM and selectors
	reservation_station #(
		.rs_size  (rs_size),
		.tag_width(tag_width)
	) u_reservation_station (
		.clock              (clock),
		.reset              (reset),
		.dispatch_valid     (dispatch_valid),
		.dispatch_class     (dispatch_class),
		.dispatch_op        (dispatch_op),
		.dispatch_dest      (dispatch_dest),
		.dispatch_src1      (dispatch_src1),
		.dispatch_src1_ready(dispatch_src1_ready),
		.dispatch_src2      (dispatch_src2),
		.dispatch_src2_ready(dispatch_src2_ready),
		.dispatch_ready     (dispatch_ready),
		.cdb_valid          (cdb_valid),
		.cdb_tag            (cdb_tag),
		.alu_issue_ready    (alu_issue_ready),
		.alu_issue_valid    (alu_issue_valid),
		.alu_issue_op       (alu_issue_op),
		.alu_issue_dest     (alu_issue_dest),
		.mult_issue_ready   (mult_issue_ready),
		.mult_issue_valid   (mult_issue_valid),
		.mult_issue_op      (mult_issue_op),
		.mult_issue_dest    (mult_issue_dest),
		.mem_issue_ready    (mem_issue_ready),
		.mem_issue_valid    (mem_issue_valid),
		.mem_issue_op       (mem_issue_op),
		.mem_issue_dest     (mem_issue_dest)
	);

endmodule

/* verilog/rs_tag_cam.sv */
////////////////////////////////////////////////////////////
// Wakeup CAM for the reservation station
// Broadcast tag against stored and dispatching sources
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rs_tag_cam #(
	parameter int rs_size   = 8,
	parameter int tag_width = 6
) (
	input  logic                 cdb_valid,
	input  logic [tag_width-1:0] cdb_tag,
	input  logic [tag_width-1:0] src1_tags [rs_size],
	input  logic [tag_width-1:0] src2_tags [rs_size],
	input  logic [tag_width-1:0] dispatch_src1,
	input  logic [tag_width-1:0] dispatch_src2,
	output logic [rs_size-1:0]   src1_hit,
	output logic [rs_size-1:0]   src2_hit,
	output logic                 dispatch_src1_hit,
	output logic                 dispatch_src2_hit
);

	////////////////////////////////////////////////////////////
	// Stored sources
	////////////////////////////////////////////////////////////

	// Busy qualification is left to the station
	always_comb begin
		for (int i = 0; i < rs_size; i++) begin
			src1_hit[i] = cdb_valid && (src1_tags[i] == cdb_tag);
			src2_hit[i] = cdb_valid && (src2_tags[i] == cdb_tag);
		end
	end

	////////////////////////////////////////////////////////////
	// Dispatch bypass
	////////////////////////////////////////////////////////////

	// Same-cycle broadcast catches the incoming instruction
	assign dispatch_src1_hit = cdb_valid && (dispatch_src1 == cdb_tag);
	assign dispatch_src2_hit = cdb_valid && (dispatch_src2 == cdb_tag);

endmodule
